//--- ams_top.f
+incdir+include
hw/ams_bus_pkg.sv
hw/ams_pdm_pkg.sv
hw/pdm_modulator.sv
hw/pdm_bank.sv
hw/ams_regs.sv
hw/ams_top.sv
verif/ams_tb.sv

//--- include/ams_tb_util.svh
/*
 * testbench helpers for the pdm block
 * xorshift source, register map rules and expected density
 */
`ifndef AMS_TB_UTIL_SVH
`define AMS_TB_UTIL_SVH

// 32 bit xorshift step, state must stay nonzero
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x;
  y = y ^ (y << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// word index outside the duty range and not the control slot
function automatic bit is_unmapped(input logic [31:0] addr,
                                   input int unsigned chn,
                                   input int unsigned ctrl_idx);
  logic [29:0] idx;
  idx = addr[31:2];
  return !((idx < chn) || (idx == ctrl_idx));
endfunction

// selected byte lanes replaced, then clipped to the register width
function automatic logic [31:0] lane_update(input logic [31:0] cur,
                                            input logic [31:0] wdata,
                                            input logic [3:0]  sel,
                                            input int unsigned width);
  logic [31:0] res;
  logic [63:0] mask;
  res  = cur;
  mask = (64'd1 << width) - 1;
  for (int b = 0; b < 4; b++) begin
    if (sel[b]) res[8*b +: 8] = wdata[8*b +: 8];
  end
  return res & mask[31:0];
endfunction

// expected ones over win clocks at divider div
function automatic longint unsigned pdm_density(input longint unsigned win,
                                                input int unsigned div,
                                                input logic [31:0] duty,
                                                input int unsigned dwc);
  longint unsigned steps;
  steps = win / (div + 1);
  return (steps * duty) >> dwc;
endfunction

`endif

//--- verif/ams_tb.sv
/*
 * testbench for the pdm output block
 * random bus traffic against a register model, pdm density and disable checks
 */
`default_nettype none

`include "ams_tb_util.svh"

module ams_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import ams_bus_pkg::*;
  import ams_pdm_pkg::*;

  localparam int unsigned DWC = 24;  // dut defaults
  localparam int unsigned CHN = 4;

  localparam int RST_CYC = 5;
  localparam int N_RW    = 200;    // readback pairs
  localparam int N_BAD   = 32;     // unmapped pairs
  localparam int WIN     = 2048;   // density window, clocks
  localparam int SETTLE  = 260;    // longest old divider period plus slack
  localparam int BUS_CYC = 4*(N_RW + N_BAD) + 12*(CHN + 1) + 4*(CHN + 3);
  localparam int WIN_CYC = 2*(SETTLE + WIN + 32) + 20;
  localparam int LIMIT   = 2*(RST_CYC + BUS_CYC + WIN_CYC);

  logic           clk = 1'b0;
  logic           rstn;
  sys_req_t       sys_req;
  sys_rsp_t       sys_rsp;
  logic [CHN-1:0] pdm;

  ams_top ams_top_i (
    .clk     (clk),
    .rstn    (rstn),
    .sys_req (sys_req),
    .sys_rsp (sys_rsp),
    .pdm     (pdm)
  );

  always #2 clk = ~clk;  // 4 ns period

  // register model, duty words and the control word
  logic [31:0] shadow_duty [CHN];
  logic [31:0] shadow_ctrl;

  logic [31:0] rng = 32'd68713;
  int          err_cnt = 0;   // all failed checks
  int          ack_err = 0;   // ack timing only
  int          issued  = 0;
  int          acked   = 0;
  int          n_pass  = 0;
  int          n_fail  = 0;
  int          cycle   = 0;
  int unsigned div_sel;       // divider shared by density tests

  function automatic logic [31:0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // model read, zero for unmapped
  function automatic logic [31:0] shadow_read(input logic [31:0] addr);
    logic [29:0] idx;
    idx = addr[31:2];
    if (is_unmapped(addr, CHN, REG_CTRL_IDX)) return '0;
    if (idx == REG_CTRL_IDX) return shadow_ctrl;
    return shadow_duty[idx];
  endfunction

  // model write, dropped for unmapped
  function automatic void shadow_write(input logic [31:0] addr,
                                       input logic [31:0] wdata,
                                       input logic [3:0]  sel);
    logic [29:0] idx;
    idx = addr[31:2];
    if (is_unmapped(addr, CHN, REG_CTRL_IDX)) return;
    if (idx == REG_CTRL_IDX) shadow_ctrl = lane_update(shadow_ctrl, wdata, sel, 16);
    else shadow_duty[idx] = lane_update(shadow_duty[idx], wdata, sel, DWC);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // bus driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_issue(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] sel, input logic wen, input logic ren);
    sys_req_t req;
    req.addr  = addr;
    req.wdata = wdata;
    req.sel   = sel;
    req.wen   = wen;
    req.ren   = ren;
    @(posedge clk);
    sys_req <= req;
  endtask

  task automatic bus_idle();
    @(posedge clk);
    sys_req <= '0;
  endtask

  // all issued requests answered, checked on the rising edge
  task automatic wait_ack();
    int n;
    n = 0;
    while (acked != issued && n < 8) begin
      @(posedge clk);
      n++;
    end
    assert (acked == issued) else begin
      $display("acknowledge count %0d does not match %0d requests", acked, issued);
      err_cnt++;
    end
  endtask

  // every duty register plus control, back to back
  task automatic read_all();
    for (int i = 0; i < CHN; i++) bus_issue(32'(i) << 2, '0, '0, 1'b0, 1'b1);
    bus_issue(32'(REG_CTRL_IDX) << 2, '0, '0, 1'b0, 1'b1);
    bus_idle();
    wait_ack();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // response monitor, model updated in request order
  ////////////////////////////////////////////////////////////////////////////

  logic        exp_ack;
  logic        exp_err;
  logic        exp_rd;     // rdata is checked
  logic [31:0] exp_rdata;

  always @(negedge clk) begin
    if (!rstn) begin
      exp_ack = 1'b0;
    end else begin
      // answer to last cycle's request
      assert (sys_rsp.ack === exp_ack) else begin
        $display("Mismatch sys_rsp.ack: expected %h, got %h", exp_ack, sys_rsp.ack);
        err_cnt++;
        ack_err++;
      end
      if (sys_rsp.ack === 1'b1) acked++;  // real acks only
      if (exp_ack) begin
        assert (sys_rsp.err === exp_err) else begin
          $display("Mismatch sys_rsp.err: expected %h, got %h", exp_err, sys_rsp.err);
          err_cnt++;
        end
        if (exp_rd) begin
          assert (sys_rsp.rdata === exp_rdata) else begin
            $display("Mismatch sys_rsp.rdata: expected %h, got %h", exp_rdata,
                     sys_rsp.rdata);
            err_cnt++;
          end
        end
      end
      // request taken at the next edge
      exp_ack = sys_req.wen | sys_req.ren;
      if (exp_ack) begin
        issued++;
        exp_err   = is_unmapped(sys_req.addr, CHN, REG_CTRL_IDX);
        exp_rd    = sys_req.ren | exp_err;  // unmapped reads zero either way
        exp_rdata = shadow_read(sys_req.addr);
        if (sys_req.wen) shadow_write(sys_req.addr, sys_req.wdata, sys_req.sel);
      end
    end
  end

  // watchdog
  always @(posedge clk) begin
    cycle++;
    if (cycle >= LIMIT) begin
      $display("run stopped after %0d cycles without finishing", LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  task automatic report(input string name, input int errs);
    if (errs == 0) begin
      $display("test %s passed", name);
      n_pass++;
    end else begin
      $display("test %s failed with %0d errors", name, errs);
      n_fail++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // density window
  ////////////////////////////////////////////////////////////////////////////

  // one sample per step period, must_low channels checked every clock
  task automatic count_window(input logic [CHN-1:0] must_low);
    int unsigned     ones [CHN];
    longint unsigned exp;
    foreach (ones[ch]) ones[ch] = 0;
    for (int c = 0; c < WIN; c++) begin
      @(negedge clk);
      for (int ch = 0; ch < CHN; ch++) begin
        if (must_low[ch]) begin
          assert (pdm[ch] === 1'b0) else begin
            $display("Mismatch pdm[%0d]: expected %h, got %h", ch, 1'b0, pdm[ch]);
            err_cnt++;
          end
        end
      end
      if (c % (div_sel + 1) == div_sel) begin
        for (int ch = 0; ch < CHN; ch++) ones[ch] += pdm[ch];
      end
    end
    for (int ch = 0; ch < CHN; ch++) begin
      if (!must_low[ch]) begin
        exp = pdm_density(WIN, div_sel, shadow_read(32'(ch) << 2), DWC);
        assert (ones[ch] + 2 >= exp && ones[ch] <= exp + 2) else begin
          $display("Mismatch pdm[%0d] ones: expected %h, got %h", ch, exp, ones[ch]);
          err_cnt++;
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          e0;
    int          idx;
    logic [31:0] r;
    logic [31:0] addr;
    logic [7:0]  off;  // channels to disable

    foreach (shadow_duty[i]) shadow_duty[i] = '0;
    shadow_ctrl = '0;
    rstn    = 1'b0;
    sys_req = '0;
    repeat (RST_CYC) @(posedge clk);
    rstn <= 1'b1;

    // reset state
    e0 = err_cnt;
    read_all();
    repeat (20) begin
      @(negedge clk);
      assert (pdm === '0) else begin
        $display("Mismatch pdm: expected %h, got %h", {CHN{1'b0}}, pdm);
        err_cnt++;
      end
    end
    report("reset", err_cnt - e0);

    // random write then read
    e0 = err_cnt;
    for (int n = 0; n < N_RW; n++) begin
      r    = rand32();
      idx  = r % (CHN + 1);
      if (idx == CHN) idx = REG_CTRL_IDX;  // control slot
      addr = (32'(idx) << 2) | r[9:8];     // low bits ignored
      bus_issue(addr, rand32(), r[7:4], 1'b1, 1'b0);
      bus_issue(addr, rand32(), r[7:4], 1'b0, 1'b1);
      bus_idle();
      wait_ack();
    end
    report("readback", err_cnt - e0);

    // holes between channels and beyond control
    e0 = err_cnt;
    for (int n = 0; n < N_BAD; n++) begin
      r = rand32();
      if (r[0]) idx = CHN + (r[15:1] % (CHN_MAX - CHN));
      else      idx = CHN_MAX + 1 + r[31:12];
      addr = 32'(idx) << 2;
      bus_issue(addr, rand32(), 4'hf, 1'b1, 1'b0);
      bus_issue(addr, '0, '0, 1'b0, 1'b1);
      bus_idle();
      wait_ack();
    end
    read_all();  // model unchanged
    report("unmapped", err_cnt - e0);
    report("ack timing", ack_err);

    // density, all enabled
    e0 = err_cnt;
    div_sel = rand32() % 16;
    bus_issue(32'(REG_CTRL_IDX) << 2, {16'h0, 8'(div_sel), 8'h00}, 4'b0011, 1'b1, 1'b0);
    bus_idle();
    wait_ack();
    repeat (SETTLE) @(posedge clk);  // new divider loaded at a wrap
    for (int i = 0; i < CHN; i++) bus_issue(32'(i) << 2, rand32(), 4'hf, 1'b1, 1'b0);
    bus_issue(32'(REG_CTRL_IDX) << 2, {16'h0, 8'(div_sel), 8'hff}, 4'b0011, 1'b1, 1'b0);
    bus_idle();
    wait_ack();
    repeat (div_sel + 3) @(posedge clk);
    count_window('0);
    report("density", err_cnt - e0);

    // disable some channels
    e0  = err_cnt;
    off = 8'(rand32() % (1 << CHN));
    if (off == 0) off = 8'h01;
    bus_issue(32'(REG_CTRL_IDX) << 2, {16'h0, 8'(div_sel), ~off}, 4'b0011, 1'b1, 1'b0);
    bus_idle();
    wait_ack();
    @(posedge clk);  // two edges after the write edge
    count_window(off[CHN-1:0]);
    report("disable", err_cnt - e0);

    $display("tests passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0 && err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : ams_tb

`default_nettype wire

//--- hw/ams_top.sv
/*
 * pdm output block top level
 * register bank on the system bus feeding the modulator bank
 */
`default_nettype none

module ams_top #(
  int unsigned DWC = 24,  // duty width, at most 32
  int unsigned CHN = 4    // channel count, at most CHN_MAX
)(
  input  logic                  clk,
  input  logic                  rstn,     // sync, active low
  // system bus
  input  ams_bus_pkg::sys_req_t sys_req,
  output ams_bus_pkg::sys_rsp_t sys_rsp,
  // pdm outputs, to the rc filters
  output logic [CHN-1:0]        pdm
);

  import ams_pdm_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // register bank to modulators
  ////////////////////////////////////////////////////////////////////////////

  logic [CHN-1:0][DWC-1:0] duty;  // duty per channel
  pdm_ctrl_t               ctrl;  // enable mask and divider

  // bus side
  ams_regs #(
    .DWC     (DWC),
    .CHN     (CHN)
  ) ams_regs_i (
    .clk     (clk),
    .rstn    (rstn),
    .sys_req (sys_req),
    .sys_rsp (sys_rsp),
    .duty    (duty),
    .ctrl    (ctrl)
  );

  // modulator side
  pdm_bank #(
    .DWC     (DWC),
    .CHN     (CHN)
  ) pdm_bank_i (
    .clk     (clk),
    .rstn    (rstn),
    .duty    (duty),
    .ctrl    (ctrl),
    .pdm     (pdm)
  );

endmodule : ams_top

`default_nettype wire

//--- hw/ams_regs.sv
/*
 * pdm register bank
 * bus decode, byte masked duty and control registers, registered response
 */
`default_nettype none

module ams_regs #(
  int unsigned DWC = 24,  // duty width
  int unsigned CHN = 4    // channel count
)(
  input  logic                    clk,
  input  logic                    rstn,     // sync, active low
  // system bus
  input  ams_bus_pkg::sys_req_t   sys_req,
  output ams_bus_pkg::sys_rsp_t   sys_rsp,
  // to modulators
  output logic [CHN-1:0][DWC-1:0] duty,     // duty per channel
  output ams_pdm_pkg::pdm_ctrl_t  ctrl      // enable mask and divider
);

  import ams_bus_pkg::*;
  import ams_pdm_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // replace selected byte lanes of cur with wdata
  function automatic logic [SYS_DW-1:0] byte_merge(
    input logic [SYS_DW-1:0] cur,
    input logic [SYS_DW-1:0] wdata,
    input logic [SYS_SW-1:0] sel
  );
    logic [SYS_DW-1:0] res;
    res = cur;
    for (int b = 0; b < SYS_SW; b++) begin
      if (sel[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  logic [SYS_AW-SYS_ALSB-1:0] idx;       // word index
  logic                       req_en;    // any request this cycle
  logic                       hit_duty;  // duty register range
  logic                       hit_ctrl;  // control register
  logic                       hit;
  logic [SYS_DW-1:0]          ctrl_wr;   // merged control word
  logic [SYS_DW-1:0]          rd_val;    // read mux

  assign idx      = sys_req.addr[SYS_AW-1:SYS_ALSB];
  assign req_en   = sys_req.wen | sys_req.ren;
  assign hit_duty = (idx < CHN);
  assign hit_ctrl = (idx == REG_CTRL_IDX);
  assign hit      = hit_duty | hit_ctrl;

  assign ctrl_wr = byte_merge(SYS_DW'(ctrl), sys_req.wdata, sys_req.sel);

  ////////////////////////////////////////////////////////////////////////////
  // write access
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      duty <= '0;
      ctrl <= '0;
    end else if (sys_req.wen) begin
      for (int i = 0; i < CHN; i++) begin
        if (idx == i) begin
          // bits above DWC dropped
          duty[i] <= DWC'(byte_merge(SYS_DW'(duty[i]), sys_req.wdata, sys_req.sel));
        end
      end
      if (hit_ctrl) ctrl <= pdm_ctrl_t'(ctrl_wr[CTRL_W-1:0]);  // low 16 bits only
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read access
  ////////////////////////////////////////////////////////////////////////////

  // zero extended, zero when unmapped
  always_comb begin
    rd_val = '0;
    for (int i = 0; i < CHN; i++) begin
      if (idx == i) rd_val = SYS_DW'(duty[i]);
    end
    if (hit_ctrl) rd_val = SYS_DW'(ctrl);
  end

  ////////////////////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////////////////////

  logic              rsp_ack;
  logic              rsp_err;
  logic [SYS_DW-1:0] rsp_rdata;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rsp_ack <= 1'b0;
      rsp_err <= 1'b0;
    end else begin
      rsp_ack <= req_en;          // exactly one cycle later
      rsp_err <= req_en & ~hit;   // unmapped index
    end
  end

  // contents at the request edge
  always_ff @(posedge clk) begin
    if (req_en) rsp_rdata <= rd_val;
  end

  always_comb begin
    sys_rsp.rdata = rsp_rdata;
    sys_rsp.err   = rsp_err;
    sys_rsp.ack   = rsp_ack;
  end

endmodule : ams_regs

`default_nettype wire

//--- hw/pdm_bank.sv
/*
 * pdm modulator bank
 * shared step prescaler and one modulator per channel
 */
`default_nettype none

module pdm_bank #(
  int unsigned DWC = 24,  // duty width
  int unsigned CHN = 4    // channel count
)(
  input  logic                    clk,
  input  logic                    rstn,   // sync, active low
  input  logic [CHN-1:0][DWC-1:0] duty,   // from register bank
  input  ams_pdm_pkg::pdm_ctrl_t  ctrl,
  output logic [CHN-1:0]          pdm     // one bit stream per channel
);

  import ams_pdm_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // prescaler
  ////////////////////////////////////////////////////////////////////////////

  logic [DIV_W-1:0] cnt;    // free running 0 .. div_q
  logic [DIV_W-1:0] div_q;  // divider in use, reloaded on wrap
  logic             step;   // common step strobe

  assign step = (cnt == div_q);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt   <= '0;
      div_q <= '0;
    end else if (step) begin
      cnt   <= '0;
      div_q <= ctrl.div;  // new divider from next period on
    end else begin
      cnt   <= cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // modulators
  ////////////////////////////////////////////////////////////////////////////

  generate
    for (genvar i = 0; i < CHN; i++) begin : g_chn
      pdm_modulator #(
        .DWC  (DWC)
      ) pdm_modulator_i (
        .clk  (clk),
        .rstn (rstn),
        .step (step),
        .en   (ctrl.en[i]),
        .duty (duty[i]),
        .pdm  (pdm[i])
      );
    end : g_chn
  endgenerate

endmodule : pdm_bank

`default_nettype wire

//--- hw/pdm_modulator.sv
/*
 * first order pdm modulator
 * accumulates duty on each step, carry out is the output bit
 */
`default_nettype none

module pdm_modulator #(
  int unsigned DWC = 24   // duty and accumulator width
)(
  input  logic           clk,
  input  logic           rstn,   // sync, active low
  input  logic           step,   // prescaler strobe
  input  logic           en,     // channel enable
  input  logic [DWC-1:0] duty,   // density, duty / 2**DWC
  output logic           pdm     // one bit stream
);

  ////////////////////////////////////////////////////////////////////////////
  // accumulator
  ////////////////////////////////////////////////////////////////////////////

  logic [DWC-1:0] acc;
  logic [DWC:0]   sum;  // one extra bit for the carry

  assign sum = {1'b0, acc} + {1'b0, duty};

  // ones over K steps = floor(K * duty / 2**DWC)
  always_ff @(posedge clk) begin
    if (!rstn) begin
      acc <= '0;
      pdm <= 1'b0;
    end else if (!en) begin
      acc <= '0;      // start clean on next enable
      pdm <= 1'b0;
    end else if (step) begin
      acc <= sum[DWC-1:0];
      pdm <= sum[DWC];  // carry out
    end
  end

endmodule : pdm_modulator

`default_nettype wire

//--- hw/ams_pdm_pkg.sv
/*
 * pdm block definitions
 * control word layout and register map
 */
`default_nettype none

package ams_pdm_pkg;

  // channel limit, CHN of the block must stay at or below it
  localparam int unsigned CHN_MAX = 8;

  localparam int unsigned DIV_W = 8;  // prescaler divider width

  ////////////////////////////////////////////////////////////////////////////
  // control word
  ////////////////////////////////////////////////////////////////////////////

  // register bits 15:8 div, 7:0 en
  typedef struct packed {
    logic [DIV_W-1:0]   div;  // step every div+1 clocks
    logic [CHN_MAX-1:0] en;   // per channel enable
  } pdm_ctrl_t;

  localparam int unsigned CTRL_W = $bits(pdm_ctrl_t);  // used bits of ctrl reg

  ////////////////////////////////////////////////////////////////////////////
  // register map, word indices
  ////////////////////////////////////////////////////////////////////////////

  // duty registers sit at 0 .. CHN-1
  localparam int unsigned REG_CTRL_IDX = CHN_MAX;  // control word

endpackage : ams_pdm_pkg

`default_nettype wire

//--- hw/ams_bus_pkg.sv
/*
 * system bus definitions for the pdm register block
 * request and response structs plus bus widths
 */
`default_nettype none

package ams_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned SYS_AW   = 32;             // byte address width
  localparam int unsigned SYS_DW   = 32;             // data width
  localparam int unsigned SYS_SW   = SYS_DW / 8;     // byte select width
  localparam int unsigned SYS_ALSB = $clog2(SYS_SW); // word index starts here

  ////////////////////////////////////////////////////////////////////////////
  // transfer structs
  ////////////////////////////////////////////////////////////////////////////

  // one request, a single cycle with wen or ren high
  typedef struct packed {
    logic [SYS_AW-1:0] addr;   // byte address
    logic [SYS_DW-1:0] wdata;  // write data
    logic [SYS_SW-1:0] sel;    // byte lanes for writes
    logic              wen;    // write strobe
    logic              ren;    // read strobe
  } sys_req_t;

  // response, ack one cycle after the request
  typedef struct packed {
    logic [SYS_DW-1:0] rdata;  // read data, valid with ack
    logic              err;    // unmapped index
    logic              ack;    // acknowledge
  } sys_rsp_t;

endpackage : ams_bus_pkg

`default_nettype wire
